//--- source/vec_pkg.sv
package vec_pkg;

    //////////////////////////////
    // Sizes
    //////////////////////////////

    localparam int VLEN          = 64;
    localparam int VLENB         = VLEN / 8;
    localparam int WORDS_PER_REG = VLEN / 32;

    // One vector register
    typedef logic [VLEN-1:0]  vreg_t;
    // Vector register number
    typedef logic [4:0]       vaddr_t;
    // Byte write enables for one register
    typedef logic [VLENB-1:0] byte_en_t;
    // Vector length, 0 to 32 elements
    typedef logic [6:0]       vl_t;
    // Scalar and memory word
    typedef logic [31:0]      word_t;

    //////////////////////////////
    // Encodings
    //////////////////////////////

    typedef enum logic [1:0] {
        NONE,
        VECTOR,
        VLOAD,
        VSTORE
    } instr_kind_e;

    typedef enum logic [3:0] {
        VNOP,
        VSETVLI,
        VADD,
        VSUB,
        VAND,
        VOR,
        VXOR,
        VMINU,
        VMAXU
    } vop_e;

    // Operand category from funct3
    typedef enum logic [2:0] {
        OPIVV = 3'b000,
        OPIVI = 3'b011,
        OPIVX = 3'b100
    } op_cat_e;

    // Encoded as log2 of the element size in bytes
    typedef enum logic [1:0] {
        EW8  = 2'd0,
        EW16 = 2'd1,
        EW32 = 2'd2
    } sew_e;

    // Encoded as log2 of the group size
    typedef enum logic [1:0] {
        LMUL_1 = 2'd0,
        LMUL_2 = 2'd1,
        LMUL_4 = 2'd2
    } lmul_e;

    typedef enum logic [1:0] {V_IDLE, V_EXEC, V_END} seq_state_e;

    typedef enum logic [1:0] {L_IDLE, L_ADDR, L_DATA, L_DONE} lsu_state_e;

    //////////////////////////////
    // Bundles
    //////////////////////////////

    typedef struct packed {
        sew_e  sew;
        lmul_e lmul;
    } vtype_t;

    typedef struct packed {
        vop_e  vop;
        vreg_t op_a;
        vreg_t op_b;
        sew_e  sew;
    } alu_req_t;

    typedef struct packed {
        word_t      addr;
        logic       rd_en;
        logic [3:0] wr_en;
        word_t      wdata;
    } mem_req_t;

    typedef struct packed {
        logic     we;
        vaddr_t   addr;
        byte_en_t be;
        vreg_t    data;
    } wb_t;

endpackage

//--- source/vec_csr.sv
`timescale 1ns/1ns

module vec_csr
    import vec_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,
    input  logic        setvl_i,
    input  word_t       avl_i,
    input  logic [10:0] zimm_i,
    output vtype_t      vtype_o,
    output vl_t         vl_o,
    output vl_t         vl_next_o
);

    sew_e  sew_new;
    lmul_e lmul_new;
    vl_t   vlmax;

    // vsew in zimm[5:3], vlmul in zimm[2:0]
    always_comb begin
        unique case (zimm_i[5:3])
            3'b000:  sew_new = EW8;
            3'b001:  sew_new = EW16;
            default: sew_new = EW32;
        endcase
        unique case (zimm_i[2:0])
            3'b000:  lmul_new = LMUL_1;
            3'b001:  lmul_new = LMUL_2;
            default: lmul_new = LMUL_4;
        endcase
    end

    // VLMAX = VLENB * LMUL / element bytes, all powers of two
    assign vlmax     = vl_t'((VLENB << lmul_new) >> sew_new);
    assign vl_next_o = (avl_i < word_t'(vlmax)) ? vl_t'(avl_i) : vlmax;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            vtype_o.sew  <= EW8;
            vtype_o.lmul <= LMUL_1;
            vl_o         <= '0;
        end
        else if (setvl_i) begin
            vtype_o.sew  <= sew_new;
            vtype_o.lmul <= lmul_new;
            vl_o         <= vl_next_o;
        end
    end

endmodule

//--- source/vec_regbank.sv
`timescale 1ns/1ns

module vec_regbank
    import vec_pkg::*;
(
    input  logic   clk,
    input  logic   reset_n,
    input  vaddr_t rs_a_i,
    input  vaddr_t rs_b_i,
    input  vaddr_t rs_c_i,
    output vreg_t  rd_a_o,
    output vreg_t  rd_b_o,
    output vreg_t  rd_c_o,
    input  wb_t    wb_i
);

    localparam int NUM_REGS = 2 ** $bits(vaddr_t);

    vreg_t regs [NUM_REGS];

    // Combinational reads
    assign rd_a_o = regs[rs_a_i];
    assign rd_b_o = regs[rs_b_i];
    assign rd_c_o = regs[rs_c_i];

    // Byte-masked write, one register per cycle
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end
        else if (wb_i.we) begin
            for (int b = 0; b < VLENB; b++) begin
                if (wb_i.be[b]) begin
                    regs[wb_i.addr][b*8 +: 8] <= wb_i.data[b*8 +: 8];
                end
            end
        end
    end

endmodule

//--- source/vec_alu.sv
`timescale 1ns/1ns

module vec_alu
    import vec_pkg::*;
(
    input  alu_req_t req_i,
    output vreg_t    result_o
);

    // One lane at up to 32 bits. Narrow lanes come in zero-extended
    // and are truncated afterwards, so carries stay inside the lane
    function automatic word_t lane_op(vop_e op, word_t a, word_t b);
        word_t res;
        unique case (op)
            VADD:    res = a + b;
            VSUB:    res = a - b;
            VAND:    res = a & b;
            VOR:     res = a | b;
            VXOR:    res = a ^ b;
            VMINU:   res = (a < b) ? a : b;
            VMAXU:   res = (a > b) ? a : b;
            default: res = a;
        endcase
        return res;
    endfunction

    logic [7:0]  a8,  b8;
    logic [15:0] a16, b16;
    word_t       a32, b32;

    always_comb begin
        result_o = '0;
        a8       = '0;
        b8       = '0;
        a16      = '0;
        b16      = '0;
        a32      = '0;
        b32      = '0;
        unique case (req_i.sew)
            EW8: begin
                // 8 lanes
                for (int i = 0; i < VLENB; i++) begin
                    a8 = req_i.op_a[i*8 +: 8];
                    b8 = req_i.op_b[i*8 +: 8];
                    result_o[i*8 +: 8] = 8'(lane_op(req_i.vop, word_t'(a8), word_t'(b8)));
                end
            end
            EW16: begin
                // 4 lanes
                for (int i = 0; i < VLENB/2; i++) begin
                    a16 = req_i.op_a[i*16 +: 16];
                    b16 = req_i.op_b[i*16 +: 16];
                    result_o[i*16 +: 16] =
                        16'(lane_op(req_i.vop, word_t'(a16), word_t'(b16)));
                end
            end
            default: begin
                // 2 lanes
                for (int i = 0; i < VLENB/4; i++) begin
                    a32 = req_i.op_a[i*32 +: 32];
                    b32 = req_i.op_b[i*32 +: 32];
                    result_o[i*32 +: 32] = lane_op(req_i.vop, a32, b32);
                end
            end
        endcase
    end

endmodule

//--- source/vec_lsu.sv
`timescale 1ns/1ns

module vec_lsu
    import vec_pkg::*;
(
    input  logic     clk,
    input  logic     reset_n,
    input  logic     start_i,
    input  logic     is_store_i,
    input  word_t    base_i,
    input  vreg_t    store_data_i,
    input  byte_en_t store_en_i,
    output mem_req_t mem_o,
    input  word_t    mem_rdata_i,
    output logic     done_o,
    output vreg_t    load_data_o
);

    lsu_state_e state;
    logic       word_sel;
    logic       is_store_r;
    logic       accept;
    logic       last_word;

    word_t    base_r;
    vreg_t    store_data_r;
    byte_en_t store_en_r;
    vreg_t    load_data_r;

    // A new register may start right on the done cycle
    assign accept    = start_i && (state == L_IDLE || state == L_DONE);
    assign last_word = (word_sel == 1'(WORDS_PER_REG - 1));

    //////////////////////////////
    // Sequencing
    //////////////////////////////

    // Two address/data pairs per register, then done
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state      <= L_IDLE;
            word_sel   <= 1'b0;
            is_store_r <= 1'b0;
        end
        else begin
            unique case (state)
                L_IDLE, L_DONE: begin
                    state    <= accept ? L_ADDR : L_IDLE;
                    word_sel <= 1'b0;
                    if (accept) begin
                        is_store_r <= is_store_i;
                    end
                end
                L_ADDR: state <= L_DATA;
                L_DATA: begin
                    state    <= last_word ? L_DONE : L_ADDR;
                    word_sel <= ~word_sel;
                end
                default: state <= L_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            base_r       <= base_i;
            store_data_r <= store_data_i;
            store_en_r   <= store_en_i;
        end
        // Read data is valid the cycle after the address
        if (state == L_DATA && !is_store_r) begin
            load_data_r[word_sel*32 +: 32] <= mem_rdata_i;
        end
    end

    //////////////////////////////
    // Memory port
    //////////////////////////////

    always_comb begin
        mem_o = '0;
        if (state == L_ADDR) begin
            mem_o.addr  = base_r + {29'b0, word_sel, 2'b00};
            mem_o.rd_en = !is_store_r;
            mem_o.wr_en = is_store_r ? store_en_r[word_sel*4 +: 4] : 4'b0000;
            mem_o.wdata = store_data_r[word_sel*32 +: 32];
        end
    end

    assign done_o      = (state == L_DONE);
    assign load_data_o = load_data_r;

endmodule

//--- source/vec_unit.sv
`timescale 1ns/1ns

module vec_unit
    import vec_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,
    input  word_t       instruction_i,
    input  instr_kind_e instr_kind_i,
    input  vop_e        vop_i,
    input  word_t       op1_scalar_i,
    input  word_t       op2_scalar_i,
    output logic        hold_o,
    output vtype_t      vtype_o,
    output vl_t         vl_o,
    output word_t       mem_address_o,
    output logic        mem_read_enable_o,
    output logic [3:0]  mem_write_enable_o,
    output word_t       mem_write_data_o,
    input  word_t       mem_read_data_i,
    output word_t       res_scalar_o,
    output logic        wr_en_scalar_o
);

    // Element e of register step s is live when s*(VLENB >> sew) + e < vl
    function automatic byte_en_t tail_mask(vl_t vl, sew_e sew, logic [2:0] step);
        byte_en_t   mask;
        logic [7:0] elem;
        for (int b = 0; b < VLENB; b++) begin
            elem    = ({2'b00, step, 3'b000} + 8'(b)) >> sew;
            mask[b] = (elem < {1'b0, vl});
        end
        return mask;
    endfunction

    vaddr_t     rd, rs1, rs2;
    op_cat_e    op_cat;
    logic       is_alu, is_mem, is_setvl;
    seq_state_e state, next_state;
    logic [2:0] step, wb_step, group_len;
    logic       alu_issue, lsu_start, lsu_done;
    vtype_t     vtype;
    vl_t        vl, vl_next;
    vreg_t      vs2_data, vs1_data, vs3_data;
    vreg_t      scalar_rep, imm_rep, alu_result, lsu_data;
    alu_req_t   alu_req;
    mem_req_t   mem_req;
    wb_t        wb;

    //////////////////////////////
    // Decode
    //////////////////////////////

    assign rd       = instruction_i[11:7];
    assign rs1      = instruction_i[19:15];
    assign rs2      = instruction_i[24:20];
    assign op_cat   = op_cat_e'(instruction_i[14:12]);
    assign is_setvl = (instr_kind_i == VECTOR) && (vop_i == VSETVLI);
    assign is_alu   = (instr_kind_i == VECTOR)
                   && (vop_i inside {VADD, VSUB, VAND, VOR, VXOR, VMINU, VMAXU});
    assign is_mem   = (instr_kind_i inside {VLOAD, VSTORE});

    vec_csr u_csr (
        .clk       (clk),
        .reset_n   (reset_n),
        .setvl_i   (is_setvl && state == V_IDLE),
        .avl_i     (op1_scalar_i),
        .zimm_i    (instruction_i[30:20]),
        .vtype_o   (vtype),
        .vl_o      (vl),
        .vl_next_o (vl_next)
    );

    assign vtype_o = vtype;
    assign vl_o    = vl;

    always_comb begin
        unique case (vtype.lmul)
            LMUL_2:  group_len = 3'd2;
            LMUL_4:  group_len = 3'd4;
            default: group_len = 3'd1;
        endcase
    end

    //////////////////////////////
    // Sequencer
    //////////////////////////////

    // step counts registers issued so far; results land one step behind
    always_comb begin
        unique case (state)
            V_IDLE:  next_state = (is_alu || is_mem) ? V_EXEC : V_IDLE;
            V_EXEC: begin
                if (step == group_len && (!is_mem || lsu_done)) begin
                    next_state = V_END;
                end
                else begin
                    next_state = V_EXEC;
                end
            end
            default: next_state = V_IDLE;
        endcase
    end

    // Low again in V_END so the core moves on
    assign hold_o = (next_state != V_IDLE);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= V_IDLE;
            step  <= '0;
        end
        else begin
            state <= next_state;
            if (alu_issue || lsu_start) begin
                step <= step + 3'd1;
            end
            else if (state != V_EXEC) begin
                step <= '0;
            end
        end
    end

    assign alu_issue = is_alu && (state == V_IDLE || (state == V_EXEC && step != group_len));
    assign lsu_start = is_mem && (state == V_IDLE
                     || (state == V_EXEC && lsu_done && step != group_len));
    assign wb_step   = step - 3'd1;

    //////////////////////////////
    // Operands
    //////////////////////////////

    vec_regbank u_regbank (
        .clk     (clk),
        .reset_n (reset_n),
        .rs_a_i  (rs2 + vaddr_t'(step)),
        .rs_b_i  (rs1 + vaddr_t'(step)),
        .rs_c_i  (rd + vaddr_t'(step)),
        .rd_a_o  (vs2_data),
        .rd_b_o  (vs1_data),
        .rd_c_o  (vs3_data),
        .wb_i    (wb)
    );

    // Core presents the vx scalar on the second operand port
    always_comb begin
        unique case (vtype.sew)
            EW8: begin
                scalar_rep = {VLENB{op2_scalar_i[7:0]}};
                imm_rep    = {VLENB{{3{rs1[4]}}, rs1}};
            end
            EW16: begin
                scalar_rep = {(VLENB/2){op2_scalar_i[15:0]}};
                imm_rep    = {(VLENB/2){{11{rs1[4]}}, rs1}};
            end
            default: begin
                scalar_rep = {(VLENB/4){op2_scalar_i}};
                imm_rep    = {(VLENB/4){{27{rs1[4]}}, rs1}};
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (alu_issue) begin
            alu_req.vop  <= vop_i;
            alu_req.sew  <= vtype.sew;
            alu_req.op_a <= vs2_data;
            unique case (op_cat)
                OPIVX:   alu_req.op_b <= scalar_rep;
                OPIVI:   alu_req.op_b <= imm_rep;
                default: alu_req.op_b <= vs1_data;
            endcase
        end
    end

    vec_alu u_alu (
        .req_i    (alu_req),
        .result_o (alu_result)
    );

    vec_lsu u_lsu (
        .clk          (clk),
        .reset_n      (reset_n),
        .start_i      (lsu_start),
        .is_store_i   (instr_kind_i == VSTORE),
        .base_i       (op1_scalar_i + {26'b0, step, 3'b000}),
        .store_data_i (vs3_data),
        .store_en_i   (tail_mask(vl, vtype.sew, step)),
        .mem_o        (mem_req),
        .mem_rdata_i  (mem_read_data_i),
        .done_o       (lsu_done),
        .load_data_o  (lsu_data)
    );

    assign mem_address_o      = mem_req.addr;
    assign mem_read_enable_o  = mem_req.rd_en;
    assign mem_write_enable_o = mem_req.wr_en;
    assign mem_write_data_o   = mem_req.wdata;

    //////////////////////////////
    // Write-back
    //////////////////////////////

    always_comb begin
        wb.we   = (state == V_EXEC) && (is_alu || (instr_kind_i == VLOAD && lsu_done));
        wb.addr = rd + vaddr_t'(wb_step);
        wb.be   = tail_mask(vl, vtype.sew, wb_step);
        wb.data = is_mem ? lsu_data : alu_result;
    end

    // vsetvli answers in the same cycle
    assign wr_en_scalar_o = is_setvl && (state == V_IDLE);
    assign res_scalar_o   = wr_en_scalar_o ? word_t'(vl_next) : '0;

endmodule

//--- verif/tb_vec_unit.sv
`timescale 1ns/1ns

module tb_vec_unit
    import vec_pkg::*;
();

    logic        clk;
    logic        reset_n;
    word_t       instruction;
    instr_kind_e instr_kind;
    vop_e        vop;
    word_t       op1_scalar;
    word_t       op2_scalar;
    word_t       mem_read_data;
    logic        hold;
    vtype_t      vtype;
    vl_t         vl;
    word_t       mem_address;
    logic        mem_read_enable;
    logic [3:0]  mem_write_enable;
    word_t       mem_write_data;
    word_t       res_scalar;
    logic        wr_en_scalar;

    // Memory seen by the DUT and the model's copy of it
    word_t mem [256];
    word_t exp_mem [256];
    vreg_t exp_regs [32];
    vl_t   exp_vl;
    int    exp_sew;
    int    exp_lmul;

    logic [31:0] lfsr;
    int          errors;
    int          protocol_errors = 0;
    int          issued;

    vec_unit u_dut (
        .clk                (clk),
        .reset_n            (reset_n),
        .instruction_i      (instruction),
        .instr_kind_i       (instr_kind),
        .vop_i              (vop),
        .op1_scalar_i       (op1_scalar),
        .op2_scalar_i       (op2_scalar),
        .hold_o             (hold),
        .vtype_o            (vtype),
        .vl_o               (vl),
        .mem_address_o      (mem_address),
        .mem_read_enable_o  (mem_read_enable),
        .mem_write_enable_o (mem_write_enable),
        .mem_write_data_o   (mem_write_data),
        .mem_read_data_i    (mem_read_data),
        .res_scalar_o       (res_scalar),
        .wr_en_scalar_o     (wr_en_scalar)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    //////////////////////////////
    // Memory model
    //////////////////////////////

    // Read data one cycle after the strobe and writes applied per byte
    always @(posedge clk) begin
        if (mem_read_enable) begin
            mem_read_data <= mem[mem_address[9:2]];
        end
        for (int b = 0; b < 4; b++) begin
            if (mem_write_enable[b]) begin
                mem[mem_address[9:2]][b*8 +: 8] <= mem_write_data[b*8 +: 8];
            end
        end
    end

    // vsetvli answers without a stall
    assert property (@(posedge clk) disable iff (!reset_n) wr_en_scalar |-> !hold)
        else begin
            protocol_errors++;
            $display("Scalar result written while hold_o was high");
        end

    // A memory access is either a read or a write
    assert property (@(posedge clk) disable iff (!reset_n)
                     !(mem_read_enable && mem_write_enable != 4'b0000))
        else begin
            protocol_errors++;
            $display("Memory read and write strobes active together");
        end

    //////////////////////////////
    // Model
    //////////////////////////////

    // Fibonacci LFSR with taps 32 22 2 1 and one step per bit
    function automatic word_t rand_bits(int n);
        word_t v;
        logic  fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic word_t lane_result(vop_e op, word_t a, word_t b);
        if (op == VADD) return a + b;
        if (op == VSUB) return a - b;
        if (op == VAND) return a & b;
        if (op == VOR) return a | b;
        if (op == VXOR) return a ^ b;
        if (op == VMINU) return (b < a) ? b : a;
        return (b > a) ? b : a;
    endfunction

    // Byte b of group register s belongs to element (8s + b) / element bytes
    function automatic logic byte_live(int s, int b);
        return (s * VLENB + b) / (1 << exp_sew) < int'(exp_vl);
    endfunction

    //////////////////////////////
    // Instruction tasks
    //////////////////////////////

    task automatic issue(input instr_kind_e kind, input vop_e op, input word_t instr,
                         input word_t s1, input word_t s2, output int hold_cycles,
                         output word_t scalar, output logic scalar_we);
        @(posedge clk);
        instr_kind  <= kind;
        vop         <= op;
        instruction <= instr;
        op1_scalar  <= s1;
        op2_scalar  <= s2;
        issued++;
        @(negedge clk);
        scalar      = res_scalar;
        scalar_we   = wr_en_scalar;
        hold_cycles = 0;
        while (hold) begin
            hold_cycles++;
            @(negedge clk);
        end
        @(posedge clk);
        instr_kind <= NONE;
        vop        <= VNOP;
    endtask

    task automatic set_vtype(input int sew, input int lmul, input word_t avl);
        int    hc;
        int    vmax;
        word_t got;
        logic  we;
        vl_t   want;
        vmax = VLENB * (1 << lmul) / (1 << sew);
        want = (avl > word_t'(vmax)) ? vl_t'(vmax) : vl_t'(avl);
        issue(VECTOR, VSETVLI, {1'b0, 5'b0, 3'(sew), 3'(lmul), 5'd0, 3'b111, 5'd1, 7'h57},
              avl, '0, hc, got, we);
        assert (we && hc == 0)
            else begin
                errors++;
                $display("vsetvli did not answer in one cycle without a stall");
            end
        assert (got == word_t'(want))
            else begin
                errors++;
                $display("Mismatch res_scalar_o: got %h expected %h", got, want);
            end
        exp_sew  = sew;
        exp_lmul = lmul;
        exp_vl   = want;
        @(negedge clk);
        assert (vl == exp_vl)
            else begin
                errors++;
                $display("Mismatch vl_o: got %h expected %h", vl, exp_vl);
            end
        assert (vtype == {2'(sew), 2'(lmul)})
            else begin
                errors++;
                $display("Mismatch vtype_o: got %h expected %h", vtype, {2'(sew), 2'(lmul)});
            end
    endtask

    task automatic load_group(input int vd, input int base);
        int    hc;
        int    addr;
        word_t unused_scalar;
        logic  unused_we;
        issue(VLOAD, VNOP, {12'b0, 5'd0, 3'b000, 5'(vd), 7'h07}, word_t'(base), '0,
              hc, unused_scalar, unused_we);
        for (int s = 0; s < (1 << exp_lmul); s++) begin
            for (int b = 0; b < VLENB; b++) begin
                addr = base + s * VLENB + b;
                if (byte_live(s, b)) begin
                    exp_regs[vd + s][b*8 +: 8] = exp_mem[addr / 4][(addr % 4)*8 +: 8];
                end
            end
        end
    endtask

    task automatic store_group(input int vs3, input int base);
        int    hc;
        int    addr;
        word_t unused_scalar;
        logic  unused_we;
        issue(VSTORE, VNOP, {12'b0, 5'd0, 3'b000, 5'(vs3), 7'h27}, word_t'(base), '0,
              hc, unused_scalar, unused_we);
        for (int s = 0; s < (1 << exp_lmul); s++) begin
            for (int b = 0; b < VLENB; b++) begin
                addr = base + s * VLENB + b;
                if (byte_live(s, b)) begin
                    exp_mem[addr / 4][(addr % 4)*8 +: 8] = exp_regs[vs3 + s][b*8 +: 8];
                end
            end
        end
    endtask

    // Sources in v4 and v8 with the result in v12
    task automatic run_alu(input vop_e op, input op_cat_e cat, input word_t scalar,
                           input logic [4:0] imm);
        int         hc;
        int         epr;
        int         ew;
        word_t      mask;
        word_t      a;
        word_t      b;
        vreg_t      res;
        word_t      unused_scalar;
        logic       unused_we;
        logic [4:0] src1;
        src1 = (cat == OPIVI) ? imm : 5'd8;
        issue(VECTOR, op, {6'b0, 1'b1, 5'd4, src1, 3'(cat), 5'd12, 7'h57}, '0, scalar,
              hc, unused_scalar, unused_we);
        assert (hc == (1 << exp_lmul) + 1)
            else begin
                errors++;
                $display("Mismatch hold_o cycles: got %h expected %h", hc, (1 << exp_lmul) + 1);
            end
        epr  = VLENB >> exp_sew;
        ew   = 8 << exp_sew;
        mask = (ew == 32) ? 32'hffff_ffff : (word_t'(1) << ew) - 1;
        for (int s = 0; s < (1 << exp_lmul); s++) begin
            res = exp_regs[12 + s];
            for (int e = 0; e < epr; e++) begin
                if (s * epr + e < int'(exp_vl)) begin
                    a = word_t'(exp_regs[4 + s] >> (e * ew)) & mask;
                    if (cat == OPIVX) b = scalar & mask;
                    else if (cat == OPIVI) b = {{27{imm[4]}}, imm} & mask;
                    else b = word_t'(exp_regs[8 + s] >> (e * ew)) & mask;
                    res = (res & ~(vreg_t'(mask) << (e * ew)))
                        | (vreg_t'(lane_result(op, a, b) & mask) << (e * ew));
                end
            end
            exp_regs[12 + s] = res;
        end
    endtask

    task automatic check_memory();
        @(negedge clk);
        for (int i = 0; i < 256; i++) begin
            assert (mem[i] == exp_mem[i])
                else begin
                    errors++;
                    $display("Mismatch mem[%0d]: got %h expected %h", i, mem[i], exp_mem[i]);
                end
        end
    endtask

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin : main
        op_cat_e cats [3];
        word_t   w;
        int      vmax;
        int      cfg;
        cats   = '{OPIVV, OPIVX, OPIVI};
        lfsr   = 32'hfb9e;
        errors = 0;
        issued = 0;
        reset_n       <= 1'b0;
        instruction   <= '0;
        instr_kind    <= NONE;
        vop           <= VNOP;
        op1_scalar    <= '0;
        op2_scalar    <= '0;
        mem_read_data <= '0;
        for (int i = 0; i < 256; i++) begin
            w          = rand_bits(32);
            mem[i]     <= w;
            exp_mem[i] = w;
        end
        for (int r = 0; r < 32; r++) begin
            exp_regs[r] = '0;
        end
        exp_vl   = '0;
        exp_sew  = 0;
        exp_lmul = 0;
        repeat (2) @(posedge clk);
        reset_n <= 1'b1;
        @(negedge clk);
        assert (!hold && !wr_en_scalar && !mem_read_enable && mem_write_enable == 4'b0000)
            else begin
                errors++;
                $display("Control outputs not idle after reset");
            end
        assert (vl == '0)
            else begin
                errors++;
                $display("Mismatch vl_o: got %h expected %h", vl, 7'h00);
            end
        // vsetvli over every width and group size
        for (int sew = 0; sew < 3; sew++) begin
            for (int lmul = 0; lmul < 3; lmul++) begin
                set_vtype(sew, lmul, rand_bits(6));
                set_vtype(sew, lmul, rand_bits(32));
            end
        end
        // Round trip through v16
        cfg = 0;
        for (int sew = 0; sew < 3; sew++) begin
            for (int lmul = 0; lmul < 3; lmul++) begin
                set_vtype(sew, lmul, rand_bits(6));
                load_group(16, cfg * 32);
                store_group(16, 384 + cfg * 32);
                check_memory();
                cfg++;
            end
        end
        // ALU in all forms followed by the tail rule
        for (int sew = 0; sew < 3; sew++) begin
            for (int lmul = 0; lmul < 3; lmul++) begin
                set_vtype(sew, lmul, 32);
                load_group(4, 704);
                load_group(8, 768);
                for (int op = int'(VADD); op <= int'(VMAXU); op++) begin
                    for (int c = 0; c < 3; c++) begin
                        run_alu(vop_e'(op), cats[c], rand_bits(32), 5'(rand_bits(5)));
                        store_group(12, 832);
                        check_memory();
                    end
                end
                vmax = VLENB * (1 << lmul) / (1 << sew);
                set_vtype(sew, lmul, rand_bits(5) % word_t'(vmax));
                run_alu(VXOR, OPIVX, rand_bits(32), 5'd0);
                set_vtype(sew, lmul, 32);
                store_group(12, 832);
                check_memory();
            end
        end
        $display("Errors: %0d check, %0d protocol", errors, protocol_errors);
        if (errors == 0 && protocol_errors == 0) begin
            $display("ALL TESTS PASSED");
        end
        else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // 400 cycles allowed per instruction issued so far
    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < 400 * (issued + 1)) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, %0d instructions, errors: %0d check, %0d protocol",
                 cycles, issued, errors, protocol_errors);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

//--- list.f
source/vec_pkg.sv
source/vec_csr.sv
source/vec_regbank.sv
source/vec_alu.sv
source/vec_lsu.sv
source/vec_unit.sv
verif/tb_vec_unit.sv

//--- Makefile
TOP = tb_vec_unit
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f list.f --top-module $(TOP)
	verilator --lint-only -f list.f --top-module vec_unit

sim:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
